/* sim/core_golden.mem */
// Line 1 is the instruction count, then one 32-bit instruction word per line,
// then one expected retire record per line as {reg_write, rd, value}
0000000010
71000005 // addi r1, r0, 5
7210FFFD // addi r2, r1, -3
13120000 // add  r3, r1, r2
84001234 // lui  r4, 0x1234
25410000 // sub  r5, r4, r1
36530000 // and  r6, r5, r3
47640000 // or   r7, r6, r4
58750000 // xor  r8, r7, r5
69180000 // sll  r9, r1, r8
70900011 // addi r0, r9, 0x11
1A000000 // add  r10, r0, r0
00000000 // nop
1B090000 // add  r11, r0, r9
2C0B0000 // sub  r12, r0, r11
7CC08000 // addi r12, r12, -32768
5DCC0000 // xor  r13, r12, r12
1100000005
1200000002
1300000007
1412340000
151233FFFB
1600000003
1712340003
180007FFF8
1905000000
0005000011
1A00000000
0000000000
1B05000000
1CFB000000
1CFAFF8000
1D00000000

/* tb.f */
common/core_pkg.sv
design/ins_queue.sv
decode/reg_file.sv
decode/idecoder.sv
design/execute.sv
design/writeback.sv
design/core_top.sv
sim/tb_core.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -j 0 --top-module tb_core -f tb.f -o Vtb_core

run: compile
	@out="$$(./obj_dir/Vtb_core 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

/* sim/tb_core.sv */
`timescale 1ns/1ps

module tb_core;
    import core_pkg::*;

    localparam int QUEUE_DEPTH    = 4;
    localparam int RETIRE_CREDITS = 2;
    localparam int GOLDEN_DEPTH   = 64;

    logic        sys_clk = 1'b0;
    logic        rst_n;
    logic        ins_valid;
    ins_t        ins_word;
    logic        retire_credit;
    logic        ins_credit;
    logic        retire_valid;
    retire_t     retire;

    logic [39:0] golden [GOLDEN_DEPTH];
    logic [15:0] lfsr;
    int          n_ins;
    int          cycle_limit;
    int          cycle;
    int          sent;
    int          retired;
    int          outstanding;
    int          due_q [$];

    core_top #(
        .QUEUE_DEPTH    (QUEUE_DEPTH),
        .RETIRE_CREDITS (RETIRE_CREDITS)
    ) core_top_inst (
        .sys_clk       (sys_clk),
        .rst_n         (rst_n),
        .ins_valid     (ins_valid),
        .ins_word      (ins_word),
        .retire_credit (retire_credit),
        .ins_credit    (ins_credit),
        .retire_valid  (retire_valid),
        .retire        (retire)
    );

    always #5 sys_clk = ~sys_clk;

    // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic take_bits(input int nbits, output int value);
        value = 0;
        for (int i = 0; i < nbits; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = value * 2 + int'(lfsr[0]);
        end
    endtask

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic expect_idle(input string phase);
        assert (!retire_valid && !ins_credit) else begin
            $display("CHECK FAILED at %0t: retire_valid or ins_credit high %s", $time, phase);
            abort_run();
        end
    endtask

    task automatic run_cycle();
        logic [36:0] expected;
        int          delay;
        int          go;
        if (ins_credit) begin
            outstanding = outstanding - 1;
        end
        assert (outstanding >= 0) else begin
            $display("Error at %0t: queue returned a credit that was never spent", $time);
            abort_run();
        end
        if (retire_valid) begin
            assert (retired < n_ins) else begin
                $display("Error at %0t: retire record after the last instruction", $time);
                abort_run();
            end
            expected = golden[1 + n_ins + retired][36:0];
            assert (retire == expected) else begin
                $display("CHECK FAILED at %0t: retire %0d got %h expected %h",
                         $time, retired, retire, expected);
                abort_run();
            end
            retired = retired + 1;
            take_bits(3, delay);
            due_q.push_back(cycle + 2 + delay);
        end
        // Slow sink returns credits in order
        retire_credit = 1'b0;
        if (due_q.size() > 0 && due_q[0] <= cycle) begin
            retire_credit = 1'b1;
            void'(due_q.pop_front());
        end
        ins_valid = 1'b0;
        if (sent < n_ins && outstanding < QUEUE_DEPTH) begin
            take_bits(1, go);
            if (go == 1) begin
                ins_valid   = 1'b1;
                ins_word    = golden[1 + sent][31:0];
                sent        = sent + 1;
                outstanding = outstanding + 1;
            end
        end
    endtask

    initial begin
        rst_n         = 1'b1;
        ins_valid     = 1'b0;
        ins_word      = '0;
        retire_credit = 1'b0;
        lfsr          = 16'd16;
        cycle         = 0;
        sent          = 0;
        retired       = 0;
        outstanding   = 0;
        $readmemh("sim/core_golden.mem", golden);
        n_ins       = int'(golden[0]);
        cycle_limit = 50 * n_ins + 100;

        repeat (8) begin
            @(posedge sys_clk);
            #1;
            expect_idle("during reset");
        end
        rst_n = 1'b0;
        @(posedge sys_clk);
        #1;
        expect_idle("in the first cycle after reset");

        while (retired < n_ins) begin
            @(posedge sys_clk);
            #1;
            cycle = cycle + 1;
            if (cycle > cycle_limit) begin
                $display("Timeout after %0d cycles: the pipeline stopped retiring at %0d of %0d",
                         cycle, retired, n_ins);
                abort_run();
            end
            run_cycle();
        end

        // Drain the sink and watch for stray records
        repeat (20) begin
            @(posedge sys_clk);
            #1;
            cycle = cycle + 1;
            run_cycle();
        end

        if (retired == n_ins && outstanding == 0 && due_q.size() == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("Error: credits did not settle after the last retire");
            abort_run();
        end
    end

endmodule

/* design/core_top.sv */
`timescale 1ns/1ps

module core_top #(
    parameter int QUEUE_DEPTH    = 4,
    parameter int RETIRE_CREDITS = 2
) (
    input  logic              sys_clk,
    input  logic              rst_n,
    input  logic              ins_valid,
    input  core_pkg::ins_t    ins_word,
    input  logic              retire_credit,
    output logic              ins_credit,
    output logic              retire_valid,
    output core_pkg::retire_t retire
);
    import core_pkg::*;

    // Raised by the last stage, freezes everything upstream
    logic                stall;

    logic                head_valid;
    ins_t                head;
    logic                pop;

    id_ex_t              id_ex;
    ex_wb_t              ex_wb;

    logic                wb_we;
    logic [REG_ID_W-1:0] wb_rd;
    logic [XLEN-1:0]     wb_data;

    ins_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) ins_queue_inst (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .ins_valid  (ins_valid),
        .ins_word   (ins_word),
        .pop        (pop),
        .ins_credit (ins_credit),
        .head_valid (head_valid),
        .head       (head)
    );

    idecoder idecoder_inst (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .head_valid (head_valid),
        .head       (head),
        .ex_fwd     (ex_wb),
        .wb_we      (wb_we),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .pop        (pop),
        .id_ex      (id_ex)
    );

    execute execute_inst (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .stall   (stall),
        .id_ex   (id_ex),
        .ex_wb   (ex_wb)
    );

    writeback #(
        .RETIRE_CREDITS (RETIRE_CREDITS)
    ) writeback_inst (
        .sys_clk       (sys_clk),
        .rst_n         (rst_n),
        .ex_wb         (ex_wb),
        .retire_credit (retire_credit),
        .stall         (stall),
        .wb_we         (wb_we),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .retire_valid  (retire_valid),
        .retire        (retire)
    );

endmodule

/* design/writeback.sv */
`timescale 1ns/1ps

module writeback #(
    parameter int RETIRE_CREDITS = 2
) (
    input  logic                          sys_clk,
    input  logic                          rst_n,
    input  core_pkg::ex_wb_t              ex_wb,
    input  logic                          retire_credit,
    output logic                          stall,
    output logic                          wb_we,
    output logic [core_pkg::REG_ID_W-1:0] wb_rd,
    output logic [core_pkg::XLEN-1:0]     wb_data,
    output logic                          retire_valid,
    output core_pkg::retire_t             retire
);
    import core_pkg::*;

    // One spare bit so an overflow stays visible
    localparam int CNT_W = $clog2(RETIRE_CREDITS + 1) + 1;

    logic [CNT_W-1:0] credit_cnt;
    logic             has_credit;

    assign has_credit   = (credit_cnt != '0);
    assign retire_valid = ex_wb.valid && has_credit;
    assign stall        = ex_wb.valid && !has_credit;

    assign wb_we   = retire_valid && ex_wb.reg_write;
    assign wb_rd   = ex_wb.rd;
    assign wb_data = ex_wb.result;

    assign retire.reg_write = ex_wb.reg_write;
    assign retire.rd        = ex_wb.rd;
    assign retire.value     = ex_wb.result;

    // Return and spend can land in the same cycle
    always_ff @(posedge sys_clk) begin
        if (rst_n) begin
            credit_cnt <= CNT_W'(RETIRE_CREDITS);
        end else begin
            credit_cnt <= credit_cnt + CNT_W'(retire_credit) - CNT_W'(retire_valid);
        end
    end

    assert property (@(posedge sys_clk) disable iff (rst_n)
        credit_cnt <= CNT_W'(RETIRE_CREDITS))
        else $error("writeback: sink returned more credits than issued");

endmodule

/* design/execute.sv */
`timescale 1ns/1ps

module execute (
    input  logic              sys_clk,
    input  logic              rst_n,
    input  logic              stall,
    input  core_pkg::id_ex_t  id_ex,
    output core_pkg::ex_wb_t  ex_wb
);
    import core_pkg::*;

    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_result;

    // LUI reuses the adder with a zero base
    assign alu_a = (id_ex.op == OP_LUI) ? '0 : id_ex.operand_a;

    always_comb begin
        case (id_ex.op)
            OP_ADD,
            OP_ADDI,
            OP_LUI:  alu_result = alu_a + id_ex.operand_b;
            OP_SUB:  alu_result = alu_a - id_ex.operand_b;
            OP_AND:  alu_result = alu_a & id_ex.operand_b;
            OP_OR:   alu_result = alu_a | id_ex.operand_b;
            OP_XOR:  alu_result = alu_a ^ id_ex.operand_b;
            OP_SLL:  alu_result = alu_a << id_ex.operand_b[4:0];
            default: alu_result = '0;
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (rst_n) begin
            ex_wb <= '0;
        end else if (!stall) begin
            ex_wb.valid     <= id_ex.valid;
            ex_wb.rd        <= id_ex.rd;
            ex_wb.reg_write <= id_ex.valid && id_ex.reg_write;
            ex_wb.result    <= alu_result;
        end
    end

endmodule

/* decode/idecoder.sv */
`timescale 1ns/1ps

module idecoder (
    input  logic                          sys_clk,
    input  logic                          rst_n,
    input  logic                          stall,
    input  logic                          head_valid,
    input  core_pkg::ins_t                head,
    input  core_pkg::ex_wb_t              ex_fwd,
    input  logic                          wb_we,
    input  logic [core_pkg::REG_ID_W-1:0] wb_rd,
    input  logic [core_pkg::XLEN-1:0]     wb_data,
    output logic                          pop,
    output core_pkg::id_ex_t              id_ex
);
    import core_pkg::*;

    logic [XLEN-1:0]     rf_rd1;
    logic [XLEN-1:0]     rf_rd2;
    logic                legal;
    opcode_e             op;
    logic                use_a;
    logic                use_b;
    logic [XLEN-1:0]     imm_val;
    id_ex_t              dec;
    id_ex_t              dx_q;
    logic [REG_ID_W-1:0] src_a_q;
    logic [REG_ID_W-1:0] src_b_q;

    reg_file reg_file_inst (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .rs1     (head.rs1),
        .rs2     (head.rs2),
        .we      (wb_we),
        .wd_id   (wb_rd),
        .wd_data (wb_data),
        .rd1     (rf_rd1),
        .rd2     (rf_rd2)
    );

    // Newest source wins; register 0 never forwards
    function automatic logic [XLEN-1:0] pick_operand(
        input logic [REG_ID_W-1:0] rs,
        input logic [XLEN-1:0]     rf_val
    );
        logic [XLEN-1:0] val;
        val = rf_val;
        if (rs != '0) begin
            if (ex_fwd.valid && ex_fwd.reg_write && ex_fwd.rd == rs) begin
                val = ex_fwd.result;
            end
        end
        return val;
    endfunction

    assign pop   = head_valid && !stall;
    assign legal = (head.opcode <= OPC_W'(OP_LUI));
    assign op    = legal ? opcode_e'(head.opcode) : OP_NOP;
    assign use_a = (op != OP_NOP) && (op != OP_LUI);
    assign use_b = (op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL});

    always_comb begin
        case (op)
            OP_ADDI: imm_val = {{(XLEN-IMM_W){head.imm[IMM_W-1]}}, head.imm};
            OP_LUI:  imm_val = {head.imm, {(XLEN-IMM_W){1'b0}}};
            default: imm_val = '0;
        endcase
    end

    always_comb begin
        dec.valid     = head_valid;
        dec.op        = op;
        dec.rd        = head.rd;
        dec.reg_write = (op != OP_NOP) && (head.rd != '0);
        dec.operand_a = use_a ? pick_operand(head.rs1, rf_rd1) : '0;
        dec.operand_b = use_b ? pick_operand(head.rs2, rf_rd2) : imm_val;
    end

    always_ff @(posedge sys_clk) begin
        if (rst_n) begin
            dx_q    <= '0;
            src_a_q <= '0;
            src_b_q <= '0;
        end else if (!stall) begin
            if (head_valid) begin
                dx_q    <= dec;
                src_a_q <= use_a ? head.rs1 : '0;
                src_b_q <= use_b ? head.rs2 : '0;
            end else begin
                // Bubble
                dx_q    <= '0;
                src_a_q <= '0;
                src_b_q <= '0;
            end
        end
    end

    // Producer directly ahead lands in ex_wb while its consumer sits here
    always_comb begin
        id_ex = dx_q;
        if (src_a_q != '0 && ex_fwd.valid && ex_fwd.reg_write && ex_fwd.rd == src_a_q) begin
            id_ex.operand_a = ex_fwd.result;
        end
        if (src_b_q != '0 && ex_fwd.valid && ex_fwd.reg_write && ex_fwd.rd == src_b_q) begin
            id_ex.operand_b = ex_fwd.result;
        end
    end

    assert property (@(posedge sys_clk) disable iff (rst_n)
        head_valid |-> legal)
        else $error("idecoder: unknown opcode %0h", head.opcode);

endmodule

/* decode/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                          sys_clk,
    input  logic                          rst_n,
    input  logic [core_pkg::REG_ID_W-1:0] rs1,
    input  logic [core_pkg::REG_ID_W-1:0] rs2,
    input  logic                          we,
    input  logic [core_pkg::REG_ID_W-1:0] wd_id,
    input  logic [core_pkg::XLEN-1:0]     wd_data,
    output logic [core_pkg::XLEN-1:0]     rd1,
    output logic [core_pkg::XLEN-1:0]     rd2
);
    import core_pkg::*;

    localparam int NREGS = 1 << REG_ID_W;

    // No storage behind register 0
    logic [XLEN-1:0] regs [1:NREGS-1];

    always_ff @(posedge sys_clk) begin
        if (rst_n) begin
            for (int i = 1; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wd_id != '0) begin
            regs[wd_id] <= wd_data;
        end
    end

    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* design/ins_queue.sv */
`timescale 1ns/1ps

module ins_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic          sys_clk,
    input  logic          rst_n,
    input  logic          ins_valid,
    input  core_pkg::ins_t ins_word,
    input  logic          pop,
    output logic          ins_credit,
    output logic          head_valid,
    output core_pkg::ins_t head
);
    import core_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    ins_t             mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pop_fire;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
    endfunction

    assign head_valid = (count != '0);
    assign head       = mem[rd_ptr];
    assign pop_fire   = pop && head_valid;

    always_ff @(posedge sys_clk) begin
        if (ins_valid) begin
            mem[wr_ptr] <= ins_word;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            ins_credit <= 1'b0;
        end else begin
            if (ins_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop_fire) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count      <= count + CNT_W'(ins_valid) - CNT_W'(pop_fire);
            // One credit back per freed entry
            ins_credit <= pop_fire;
        end
    end

    // Source must hold a credit to send
    assert property (@(posedge sys_clk) disable iff (rst_n)
        !(ins_valid && count == CNT_W'(QUEUE_DEPTH)))
        else $error("ins_queue: word pushed into a full queue");

endmodule

/* common/core_pkg.sv */
package core_pkg;

    localparam int XLEN     = 32;
    localparam int REG_ID_W = 4;
    localparam int OPC_W    = 4;
    localparam int IMM_W    = 16;

    typedef enum logic [OPC_W-1:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_AND  = 4'h3,
        OP_OR   = 4'h4,
        OP_XOR  = 4'h5,
        OP_SLL  = 4'h6,
        OP_ADDI = 4'h7,
        OP_LUI  = 4'h8
    } opcode_e;

    // Raw instruction word as it arrives on the input port
    typedef struct packed {
        logic [OPC_W-1:0]    opcode;
        logic [REG_ID_W-1:0] rd;
        logic [REG_ID_W-1:0] rs1;
        logic [REG_ID_W-1:0] rs2;
        logic [IMM_W-1:0]    imm;
    } ins_t;

    // Decode to execute
    typedef struct packed {
        logic                valid;
        opcode_e             op;
        logic [REG_ID_W-1:0] rd;
        logic                reg_write;
        logic [XLEN-1:0]     operand_a;
        logic [XLEN-1:0]     operand_b;
    } id_ex_t;

    // Execute to writeback, also the newest forwarding source
    typedef struct packed {
        logic                valid;
        logic [REG_ID_W-1:0] rd;
        logic                reg_write;
        logic [XLEN-1:0]     result;
    } ex_wb_t;

    typedef struct packed {
        logic                reg_write;
        logic [REG_ID_W-1:0] rd;
        logic [XLEN-1:0]     value;
    } retire_t;

endpackage
